/* battle_pkg.sv */
// battle scene types
package battle_pkg;

   // raster coordinate
   typedef struct packed {
      logic [9:0] x;
      logic [9:0] y;
   } draw_pos_t;

   // hit points, max is never zero
   typedef struct packed {
      logic [6:0] cur;
      logic [6:0] max;
   } hp_t;

   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } rgb_t;

   // window hits, also carried as a plain 4 bit word
   typedef struct packed {
      logic my_spr;
      logic en_spr;
      logic my_bar;
      logic en_bar;
   } hits_t;

   // stage 1 result
   typedef struct packed {
      hits_t       hits;
      logic [5:0]  my_spr_x;
      logic [5:0]  my_spr_y;
      logic [5:0]  en_spr_x;
      logic [5:0]  en_spr_y;
      // box offsets, border ring included
      logic [5:0]  my_bar_x;
      logic [2:0]  my_bar_y;
      logic [5:0]  en_bar_x;
      logic [2:0]  en_bar_y;
      logic [2:0]  my_id;
      logic [2:0]  en_id;
      hp_t         my_hp;
      hp_t         en_hp;
   } locate_t;

   // stage 2 bar result
   typedef struct packed {
      logic hit;
      rgb_t rgb;
   } shade_t;

   typedef enum logic [1:0] {
      pix_none   = 2'd0,
      pix_sprite = 2'd1,
      pix_colour = 2'd2
   } pixel_kind_t;

   // sheet address, zero padded to the colour width
   typedef struct packed {
      logic [4:0]  pad;
      logic [18:0] addr;
   } spr_word_t;

   // one word, read according to kind
   typedef union packed {
      spr_word_t spr;
      rgb_t      rgb;
   } pixel_data_u;

   typedef struct packed {
      pixel_kind_t kind;
      pixel_data_u data;
   } pixel_out_t;

endpackage

/* battle_scene_top.f */
+incdir+.
battle_pkg.sv
pixel_locate.sv
sprite_addr_gen.sv
hp_fill_shade.sv
layer_merge.sv
battle_scene_top.sv
tb_battle_scene.sv

/* battle_scene_top.sv */
// battle scene pixel pipeline
`timescale 1ns/1ps

module battle_scene_top
   import battle_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  draw_pos_t  draw,
   input  logic [2:0] my_id,
   input  logic [2:0] en_id,
   input  hp_t        my_hp,
   input  hp_t        en_hp,
   output pixel_out_t pix
);

   // stage 1 to stage 2
   locate_t     loc;
   // stage 2 to stage 3
   logic [18:0] my_addr;
   logic [18:0] en_addr;
   shade_t      my_shade;
   shade_t      en_shade;

   pixel_locate i_locate (
      .clk(clk), .arst_n(arst_n), .draw(draw),
      .my_id(my_id), .en_id(en_id),
      .my_hp(my_hp), .en_hp(en_hp), .loc(loc)
   );

   // player shows its back
   sprite_addr_gen #(.BACK(1'b1)) i_my_addr (
      .clk(clk), .arst_n(arst_n), .id(loc.my_id),
      .off_x(loc.my_spr_x), .off_y(loc.my_spr_y), .addr(my_addr)
   );

   // enemy faces the player
   sprite_addr_gen #(.BACK(1'b0)) i_en_addr (
      .clk(clk), .arst_n(arst_n), .id(loc.en_id),
      .off_x(loc.en_spr_x), .off_y(loc.en_spr_y), .addr(en_addr)
   );

   hp_fill_shade i_my_shade (
      .clk(clk), .arst_n(arst_n), .hit(loc.hits.my_bar),
      .off_x(loc.my_bar_x), .off_y(loc.my_bar_y), .hp(loc.my_hp), .shade(my_shade)
   );

   hp_fill_shade i_en_shade (
      .clk(clk), .arst_n(arst_n), .hit(loc.hits.en_bar),
      .off_x(loc.en_bar_x), .off_y(loc.en_bar_y), .hp(loc.en_hp), .shade(en_shade)
   );

   // flags skip stage 2 through the merge input register
   layer_merge i_merge (
      .clk(clk), .arst_n(arst_n), .loc_hits(loc.hits),
      .my_addr(my_addr), .en_addr(en_addr),
      .my_shade(my_shade), .en_shade(en_shade), .pix(pix)
   );

endmodule

/* battle_settings.svh */
// battle scene settings
`ifndef BATTLE_SETTINGS_SVH
`define BATTLE_SETTINGS_SVH

// player creature, back view, top left corner
`define MY_X 10'd250
`define MY_Y 10'd290

// enemy creature, front view, top left corner
`define EN_X 10'd410
`define EN_Y 10'd160

// square sprite edge in pixels
`define SPR_SIZE 10'd56

// sheet row is four sprites wide
`define SHEET_W 10'd224

// first fill pixel of the player bar
`define MY_BAR_X 10'd280
`define MY_BAR_Y 10'd360

// first fill pixel of the enemy bar
`define EN_BAR_X 10'd130
`define EN_BAR_Y 10'd60

// fill area only, border ring sits outside it
`define BAR_W 10'd50
`define BAR_H 10'd5

// bar colours, r g b
`define COL_GREEN 24'h41ff74
`define COL_ORANGE 24'h41cc00
`define COL_RED 24'hff3300
`define COL_WHITE 24'hffffff
`define COL_BLACK 24'h000000

`endif

/* hp_fill_shade.sv */
// health bar shader
`timescale 1ns/1ps
`include "battle_settings.svh"

module hp_fill_shade
   import battle_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       hit,
   // offsets within the box, border included
   input  logic [5:0] off_x,
   input  logic [2:0] off_y,
   input  hp_t        hp,
   output shade_t     shade
);

   // 50 x 127 needs 13 bits
   logic [12:0] scaled;
   logic [12:0] quot;
   // filled inner columns, 0 to 50
   logic [5:0]  fill_w;
   logic        border;
   logic        filled;
   rgb_t        fill_rgb;
   rgb_t        rgb_d;

   assign scaled = 13'(`BAR_W) * 13'(hp.cur);
   // max of zero is outside the input contract, keep the divider quiet
   assign quot   = (hp.max == 7'd0) ? 13'd0 : scaled / 13'(hp.max);
   assign fill_w = quot[5:0];

   // outer ring of the box
   assign border = (off_x == 6'd0) || (off_x == 6'(`BAR_W + 10'd1)) ||
                   (off_y == 3'd0) || (off_y == 3'(`BAR_H + 10'd1));

   // inner column off_x - 1 is left of the fill edge
   assign filled = (off_x != 6'd0) && (off_x <= fill_w);

   // tier by how much of the bar is left
   always_comb begin
      if ({1'b0, fill_w, 1'b0} > 8'(`BAR_W)) begin
         // above half
         fill_rgb = `COL_GREEN;
      end else if (8'(fill_w) * 8'd5 > 8'(`BAR_W)) begin
         // above a fifth
         fill_rgb = `COL_ORANGE;
      end else begin
         fill_rgb = `COL_RED;
      end
   end

   always_comb begin
      if (border) begin
         rgb_d = `COL_BLACK;
      end else if (filled) begin
         rgb_d = fill_rgb;
      end else begin
         // empty part of the bar
         rgb_d = `COL_WHITE;
      end
   end

   // stage 2 register, hit passes along
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         shade <= '0;
      end else begin
         shade.hit <= hit;
         shade.rgb <= rgb_d;
      end
   end

endmodule

/* layer_merge.sv */
// layer priority merge
`timescale 1ns/1ps

module layer_merge
   import battle_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   // stage 1 flags, realigned here
   input  logic [3:0]  loc_hits,
   input  logic [18:0] my_addr,
   input  logic [18:0] en_addr,
   input  shade_t      my_shade,
   input  shade_t      en_shade,
   output pixel_out_t  pix
);

   // flags lined up with the stage 2 results
   hits_t      hits_q;
   pixel_out_t pix_d;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hits_q <= '0;
      end else begin
         hits_q <= loc_hits;
      end
   end

   // bars above sprites, player above enemy
   always_comb begin
      pix_d = '0;
      if (my_shade.hit) begin
         pix_d.kind     = pix_colour;
         pix_d.data.rgb = my_shade.rgb;
      end else if (en_shade.hit) begin
         pix_d.kind     = pix_colour;
         pix_d.data.rgb = en_shade.rgb;
      end else if (hits_q.my_spr) begin
         pix_d.kind          = pix_sprite;
         pix_d.data.spr.addr = my_addr;
      end else if (hits_q.en_spr) begin
         pix_d.kind          = pix_sprite;
         pix_d.data.spr.addr = en_addr;
      end
   end

   // stage 3 register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pix <= '0;
      end else begin
         pix <= pix_d;
      end
   end

   // screen layout keeps bars and sprites apart
   a_layer_disjoint: assert property (@(posedge clk) disable iff (!arst_n)
      !((hits_q.my_bar || hits_q.en_bar) && (hits_q.my_spr || hits_q.en_spr)))
      else $error("bar and sprite overlap");

endmodule

/* pixel_locate.sv */
// pixel window locator
`timescale 1ns/1ps
`include "battle_settings.svh"

module pixel_locate
   import battle_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  draw_pos_t draw,
   input  logic [2:0] my_id,
   input  logic [2:0] en_id,
   input  hp_t       my_hp,
   input  hp_t       en_hp,
   output locate_t   loc
);

   // coordinate relative to each origin
   logic [9:0] my_dx, my_dy;
   logic [9:0] en_dx, en_dy;
   logic [9:0] mb_dx, mb_dy;
   logic [9:0] eb_dx, eb_dy;
   locate_t    loc_d;

   // pos inside [org, org + len)
   function automatic logic in_span(input logic [9:0] pos, input logic [9:0] org,
                                    input logic [9:0] len);
      logic [9:0] rel;
      rel = pos - org;
      return (pos >= org) && (rel < len);
   endfunction

   // bar box starts one pixel up and left of the fill
   assign my_dx = draw.x - `MY_X;
   assign my_dy = draw.y - `MY_Y;
   assign en_dx = draw.x - `EN_X;
   assign en_dy = draw.y - `EN_Y;
   assign mb_dx = draw.x - (`MY_BAR_X - 10'd1);
   assign mb_dy = draw.y - (`MY_BAR_Y - 10'd1);
   assign eb_dx = draw.x - (`EN_BAR_X - 10'd1);
   assign eb_dy = draw.y - (`EN_BAR_Y - 10'd1);

   always_comb begin
      loc_d.hits.my_spr = in_span(draw.x, `MY_X, `SPR_SIZE) &&
                          in_span(draw.y, `MY_Y, `SPR_SIZE);
      loc_d.hits.en_spr = in_span(draw.x, `EN_X, `SPR_SIZE) &&
                          in_span(draw.y, `EN_Y, `SPR_SIZE);
      // 52 x 7 box around each fill
      loc_d.hits.my_bar = in_span(draw.x, `MY_BAR_X - 10'd1, `BAR_W + 10'd2) &&
                          in_span(draw.y, `MY_BAR_Y - 10'd1, `BAR_H + 10'd2);
      loc_d.hits.en_bar = in_span(draw.x, `EN_BAR_X - 10'd1, `BAR_W + 10'd2) &&
                          in_span(draw.y, `EN_BAR_Y - 10'd1, `BAR_H + 10'd2);
      // low bits only, meaningful when the hit is set
      loc_d.my_spr_x = my_dx[5:0];
      loc_d.my_spr_y = my_dy[5:0];
      loc_d.en_spr_x = en_dx[5:0];
      loc_d.en_spr_y = en_dy[5:0];
      loc_d.my_bar_x = mb_dx[5:0];
      loc_d.my_bar_y = mb_dy[2:0];
      loc_d.en_bar_x = eb_dx[5:0];
      loc_d.en_bar_y = eb_dy[2:0];
      loc_d.my_id    = my_id;
      loc_d.en_id    = en_id;
      loc_d.my_hp    = my_hp;
      loc_d.en_hp    = en_hp;
   end

   // stage 1 register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         loc <= '0;
      end else begin
         loc <= loc_d;
      end
   end

   // hit point contract for the bar divider
   a_my_hp_range: assert property (@(posedge clk) disable iff (!arst_n)
      (my_hp.max != 7'd0) && (my_hp.cur <= my_hp.max))
      else $error("player hp out of range");

   a_en_hp_range: assert property (@(posedge clk) disable iff (!arst_n)
      (en_hp.max != 7'd0) && (en_hp.cur <= en_hp.max))
      else $error("enemy hp out of range");

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the battle scene testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_battle_scene \
   -f battle_scene_top.f -o tb_battle_scene
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_battle_scene > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
   echo "simulation reported failure"
   exit 1
fi

exit 0

/* sprite_addr_gen.sv */
// sprite sheet address generator
`timescale 1ns/1ps
`include "battle_settings.svh"

module sprite_addr_gen #(
   // 1 back view, 0 front view
   parameter bit BACK = 1'b1
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic [2:0]  id,
   input  logic [5:0]  off_x,
   input  logic [5:0]  off_y,
   output logic [18:0] addr
);

   // sprite cell in the 4 x 4 sheet
   logic [1:0]  col;
   logic [1:0]  row;
   // pixel position in the whole sheet
   logic [18:0] sheet_x;
   logic [18:0] sheet_y;
   logic [18:0] addr_d;

   // creatures pair up per row
   // even cols back view, odd cols front view
   assign col = {id[0], ~BACK};
   assign row = id[2:1];

   always_comb begin
      sheet_x = 19'(col) * 19'(`SPR_SIZE) + 19'(off_x);
      sheet_y = 19'(row) * 19'(`SPR_SIZE) + 19'(off_y);
      // row major, one sheet row per raster line
      addr_d  = sheet_x + 19'(`SHEET_W) * sheet_y;
   end

   // stage 2 register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         addr <= '0;
      end else begin
         addr <= addr_d;
      end
   end

endmodule

/* tb_battle_vectors.svh */
// directed pixel vectors
`ifndef TB_BATTLE_VECTORS_SVH
`define TB_BATTLE_VECTORS_SVH

   // columns: x, y, player id, enemy id, player hp, enemy hp, kind, data
   // hit points are out of VEC_HP_MAX
   typedef struct packed {
      logic [9:0]  x;
      logic [9:0]  y;
      logic [2:0]  my_id;
      logic [2:0]  en_id;
      logic [6:0]  my_cur;
      logic [6:0]  en_cur;
      pixel_kind_t kind;
      logic [23:0] data;
   } vec_t;

   localparam logic [6:0] VEC_HP_MAX = 7'd100;
   localparam int NUM_VECTORS = 29;

   localparam vec_t VECTORS [NUM_VECTORS] = '{
      // player bar, full, 60, 30 and 10 percent, fill edge then first empty column
      '{10'd280, 10'd362, 3'd0, 3'd0, 7'd100, 7'd100, pix_colour, 24'h41ff74},
      '{10'd329, 10'd362, 3'd0, 3'd0, 7'd100, 7'd100, pix_colour, 24'h41ff74},
      '{10'd309, 10'd362, 3'd0, 3'd0, 7'd60,  7'd100, pix_colour, 24'h41ff74},
      '{10'd310, 10'd362, 3'd0, 3'd0, 7'd60,  7'd100, pix_colour, 24'hffffff},
      '{10'd294, 10'd362, 3'd0, 3'd0, 7'd30,  7'd100, pix_colour, 24'h41cc00},
      '{10'd295, 10'd362, 3'd0, 3'd0, 7'd30,  7'd100, pix_colour, 24'hffffff},
      '{10'd284, 10'd362, 3'd0, 3'd0, 7'd10,  7'd100, pix_colour, 24'hff3300},
      '{10'd285, 10'd362, 3'd0, 3'd0, 7'd10,  7'd100, pix_colour, 24'hffffff},
      // player bar border, left right top bottom
      '{10'd279, 10'd362, 3'd0, 3'd0, 7'd100, 7'd100, pix_colour, 24'h000000},
      '{10'd330, 10'd362, 3'd0, 3'd0, 7'd100, 7'd100, pix_colour, 24'h000000},
      '{10'd300, 10'd359, 3'd0, 3'd0, 7'd100, 7'd100, pix_colour, 24'h000000},
      '{10'd300, 10'd365, 3'd0, 3'd0, 7'd100, 7'd100, pix_colour, 24'h000000},
      // enemy bar
      '{10'd130, 10'd61,  3'd0, 3'd0, 7'd100, 7'd30,  pix_colour, 24'h41cc00},
      '{10'd180, 10'd62,  3'd0, 3'd0, 7'd100, 7'd10,  pix_colour, 24'h000000},
      '{10'd150, 10'd59,  3'd0, 3'd0, 7'd100, 7'd100, pix_colour, 24'h000000},
      '{10'd129, 10'd63,  3'd0, 3'd0, 7'd100, 7'd100, pix_colour, 24'h000000},
      '{10'd150, 10'd65,  3'd0, 3'd0, 7'd100, 7'd100, pix_colour, 24'h000000},
      '{10'd154, 10'd62,  3'd0, 3'd0, 7'd100, 7'd60,  pix_colour, 24'h41ff74},
      '{10'd135, 10'd62,  3'd0, 3'd0, 7'd100, 7'd10,  pix_colour, 24'hffffff},
      // sprite corners
      '{10'd250, 10'd290, 3'd0, 3'd0, 7'd100, 7'd100, pix_sprite, 24'h000000},
      '{10'd305, 10'd345, 3'd7, 3'd0, 7'd100, 7'd100, pix_sprite, 24'h00c3c7},
      '{10'd410, 10'd160, 3'd0, 3'd0, 7'd100, 7'd100, pix_sprite, 24'h000038},
      '{10'd465, 10'd215, 3'd0, 3'd5, 7'd100, 7'd100, pix_sprite, 24'h0092ff},
      // one pixel outside a window
      '{10'd249, 10'd290, 3'd0, 3'd0, 7'd100, 7'd100, pix_none,   24'h000000},
      '{10'd306, 10'd345, 3'd0, 3'd0, 7'd100, 7'd100, pix_none,   24'h000000},
      '{10'd410, 10'd159, 3'd0, 3'd0, 7'd100, 7'd100, pix_none,   24'h000000},
      '{10'd466, 10'd215, 3'd0, 3'd0, 7'd100, 7'd100, pix_none,   24'h000000},
      '{10'd150, 10'd66,  3'd0, 3'd0, 7'd100, 7'd100, pix_none,   24'h000000},
      '{10'd181, 10'd62,  3'd0, 3'd0, 7'd100, 7'd100, pix_none,   24'h000000}
   };

`endif

/* tb_battle_scene.sv */
// battle scene testbench
`timescale 1ns/1ps
`include "battle_settings.svh"

module tb_battle_scene
   import battle_pkg::*;
();

   `include "tb_battle_vectors.svh"

   localparam int  RESET_CYCLES = 10;
   localparam int  DRAIN_LIMIT  = 8;
   localparam int  RAND_PIXELS  = 64;
   localparam hp_t FULL_HP      = '{7'd100, 7'd100};

   logic        clk;
   logic        arst_n;
   draw_pos_t   draw;
   logic [2:0]  my_id;
   logic [2:0]  en_id;
   hp_t         my_hp;
   hp_t         en_hp;
   pixel_out_t  pix;
   // expected words of the pixels in flight, oldest first
   pixel_out_t  exp_q[$];
   logic [15:0] lfsr;
   int          checks;
   int          errors;
   bit          timed_out;

   battle_scene_top i_dut (
      .clk(clk), .arst_n(arst_n), .draw(draw), .my_id(my_id), .en_id(en_id),
      .my_hp(my_hp), .en_hp(en_hp), .pix(pix)
   );

   // 100 ns period
   always #50 clk = ~clk;

   // fibonacci, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one step per bit taken
   task automatic take_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         val  = (val << 1) | int'(lfsr[0]);
      end
   endtask

   // max 1..127, cur 0..max
   task automatic rand_hp(output hp_t hp);
      int v;
      take_bits(7, v);
      hp.max = 7'(1 + v % 127);
      take_bits(7, v);
      hp.cur = 7'(v % (int'(hp.max) + 1));
   endtask

   function automatic bit in_rect(input int dx, input int dy, input int w, input int h);
      return dx >= 0 && dx < w && dy >= 0 && dy < h;
   endfunction

   // box offsets, 0 is the border column or row
   function automatic rgb_t bar_colour(input int bx, input int by, input hp_t hp);
      int fill;
      fill = int'(`BAR_W) * int'(hp.cur) / int'(hp.max);
      if (bx == 0 || by == 0 || bx == int'(`BAR_W) + 1 || by == int'(`BAR_H) + 1) begin
         return `COL_BLACK;
      end else if (bx - 1 >= fill) begin
         return `COL_WHITE;
      end else if (2 * fill > int'(`BAR_W)) begin
         return `COL_GREEN;
      end else if (5 * fill > int'(`BAR_W)) begin
         return `COL_ORANGE;
      end
      return `COL_RED;
   endfunction

   // low id bit picks the column pair, front view one column right
   function automatic logic [18:0] sheet_addr(input int id, input bit front, input int ox,
                                              input int oy);
      int col;
      int row;
      col = 2 * (id % 2) + int'(front);
      row = id / 2;
      return 19'(col * int'(`SPR_SIZE) + ox +
                 int'(`SHEET_W) * (row * int'(`SPR_SIZE) + oy));
   endfunction

   // reference model of one output word
   function automatic pixel_out_t expected_pixel(input draw_pos_t d, input logic [2:0] mid,
                                                 input logic [2:0] eid, input hp_t mhp,
                                                 input hp_t ehp);
      pixel_out_t p;
      int         mbx;
      int         mby;
      int         ebx;
      int         eby;
      int         mx;
      int         my;
      int         ex;
      int         ey;
      int         sz;
      p   = '0;
      sz  = int'(`SPR_SIZE);
      mbx = int'(d.x) - int'(`MY_BAR_X) + 1;
      mby = int'(d.y) - int'(`MY_BAR_Y) + 1;
      ebx = int'(d.x) - int'(`EN_BAR_X) + 1;
      eby = int'(d.y) - int'(`EN_BAR_Y) + 1;
      mx  = int'(d.x) - int'(`MY_X);
      my  = int'(d.y) - int'(`MY_Y);
      ex  = int'(d.x) - int'(`EN_X);
      ey  = int'(d.y) - int'(`EN_Y);
      // player bar, enemy bar, player sprite, enemy sprite
      if (in_rect(mbx, mby, int'(`BAR_W) + 2, int'(`BAR_H) + 2)) begin
         p.kind     = pix_colour;
         p.data.rgb = bar_colour(mbx, mby, mhp);
      end else if (in_rect(ebx, eby, int'(`BAR_W) + 2, int'(`BAR_H) + 2)) begin
         p.kind     = pix_colour;
         p.data.rgb = bar_colour(ebx, eby, ehp);
      end else if (in_rect(mx, my, sz, sz)) begin
         p.kind          = pix_sprite;
         p.data.spr.addr = sheet_addr(int'(mid), 1'b0, mx, my);
      end else if (in_rect(ex, ey, sz, sz)) begin
         p.kind          = pix_sprite;
         p.data.spr.addr = sheet_addr(int'(eid), 1'b1, ex, ey);
      end
      return p;
   endfunction

   task automatic check_pix(input pixel_out_t want);
      checks++;
      assert (pix == want) else begin
         errors++;
         $display("Mismatch pix: kind %h data %h, expected kind %h data %h",
                  pix.kind, pix.data, want.kind, want.data);
      end
   endtask

   // new pixel every falling edge, its word shows up three falling edges later
   task automatic apply_pixel(input draw_pos_t d, input logic [2:0] mid, input logic [2:0] eid,
                              input hp_t mhp, input hp_t ehp, input pixel_out_t want);
      @(negedge clk);
      if (exp_q.size() == 3) begin
         check_pix(exp_q.pop_front());
      end
      draw  = d;
      my_id = mid;
      en_id = eid;
      my_hp = mhp;
      en_hp = ehp;
      exp_q.push_back(want);
   endtask

   // (0,0) lies outside every window
   task automatic apply_idle();
      apply_pixel('0, 3'd0, 3'd0, FULL_HP, FULL_HP, '0);
   endtask

   task automatic reset_dut();
      int waited;
      waited = 0;
      arst_n = 1'b0;
      // registers clear while reset is held
      while (pix !== '0 && waited < RESET_CYCLES) begin
         @(negedge clk);
         waited++;
      end
      if (pix !== '0) begin
         timed_out = 1'b1;
         $display("timeout: output did not clear during reset");
         return;
      end
      // rest of the reset window, output must stay clear
      for (int i = waited; i < RESET_CYCLES; i++) begin
         apply_idle();
      end
      arst_n = 1'b1;
   endtask

   task automatic run_table();
      draw_pos_t  d;
      hp_t        mhp;
      hp_t        ehp;
      pixel_out_t want;
      for (int i = 0; i < NUM_VECTORS; i++) begin
         d.x       = VECTORS[i].x;
         d.y       = VECTORS[i].y;
         mhp.cur   = VECTORS[i].my_cur;
         mhp.max   = VEC_HP_MAX;
         ehp.cur   = VECTORS[i].en_cur;
         ehp.max   = VEC_HP_MAX;
         want.kind = VECTORS[i].kind;
         want.data = VECTORS[i].data;
         apply_pixel(d, VECTORS[i].my_id, VECTORS[i].en_id, mhp, ehp, want);
      end
   endtask

   // four corners then two random points of one sprite window
   task automatic sprite_window(input bit enemy, input int id);
      draw_pos_t  d;
      logic [2:0] mid;
      logic [2:0] eid;
      hp_t        mhp;
      hp_t        ehp;
      int         ox;
      int         oy;
      int         v;
      for (int k = 0; k < 6; k++) begin
         if (k < 4) begin
            ox = (k % 2) * (int'(`SPR_SIZE) - 1);
            oy = (k / 2) * (int'(`SPR_SIZE) - 1);
         end else begin
            take_bits(6, v);
            ox = v % int'(`SPR_SIZE);
            take_bits(6, v);
            oy = v % int'(`SPR_SIZE);
         end
         // the other creature gets a random id
         take_bits(3, v);
         mid = enemy ? 3'(v) : 3'(id);
         eid = enemy ? 3'(id) : 3'(v);
         rand_hp(mhp);
         rand_hp(ehp);
         d.x = enemy ? 10'(int'(`EN_X) + ox) : 10'(int'(`MY_X) + ox);
         d.y = enemy ? 10'(int'(`EN_Y) + oy) : 10'(int'(`MY_Y) + oy);
         apply_pixel(d, mid, eid, mhp, ehp, expected_pixel(d, mid, eid, mhp, ehp));
      end
   endtask

   // back to back pixels around every window, two pixel margin
   task automatic random_stream();
      draw_pos_t  d;
      logic [2:0] mid;
      logic [2:0] eid;
      hp_t        mhp;
      hp_t        ehp;
      int         x0;
      int         y0;
      int         w;
      int         h;
      int         v;
      for (int n = 0; n < RAND_PIXELS; n++) begin
         take_bits(2, v);
         w  = int'(`BAR_W) + 2;
         h  = int'(`BAR_H) + 2;
         x0 = int'(`EN_BAR_X) - 1;
         y0 = int'(`EN_BAR_Y) - 1;
         if (v == 0) begin
            x0 = int'(`MY_X);
            y0 = int'(`MY_Y);
         end else if (v == 1) begin
            x0 = int'(`EN_X);
            y0 = int'(`EN_Y);
         end else if (v == 2) begin
            x0 = int'(`MY_BAR_X) - 1;
            y0 = int'(`MY_BAR_Y) - 1;
         end
         if (v < 2) begin
            w = int'(`SPR_SIZE);
            h = int'(`SPR_SIZE);
         end
         take_bits(7, v);
         d.x = 10'(x0 - 2 + v % (w + 4));
         take_bits(6, v);
         d.y = 10'(y0 - 2 + v % (h + 4));
         take_bits(3, v);
         mid = 3'(v);
         take_bits(3, v);
         eid = 3'(v);
         rand_hp(mhp);
         rand_hp(ehp);
         apply_pixel(d, mid, eid, mhp, ehp, expected_pixel(d, mid, eid, mhp, ehp));
      end
   endtask

   // collect the words still in the pipe
   task automatic drain_pipeline();
      int guard;
      guard = 0;
      while (exp_q.size() != 0 && guard < DRAIN_LIMIT) begin
         @(negedge clk);
         draw = '0;
         check_pix(exp_q.pop_front());
         guard++;
      end
      if (exp_q.size() != 0) begin
         timed_out = 1'b1;
         $display("timeout: pipeline did not drain");
      end
   endtask

   task automatic run_tests();
      reset_dut();
      if (timed_out) begin
         return;
      end
      run_table();
      for (int id = 0; id < 8; id++) begin
         sprite_window(1'b0, id);
         sprite_window(1'b1, id);
      end
      random_stream();
      drain_pipeline();
   endtask

   initial begin
      clk       = 1'b0;
      arst_n    = 1'b0;
      draw      = '0;
      my_id     = 3'd0;
      en_id     = 3'd0;
      my_hp     = FULL_HP;
      en_hp     = FULL_HP;
      lfsr      = 16'd60188;
      checks    = 0;
      errors    = 0;
      timed_out = 1'b0;
      run_tests();
      if (timed_out) begin
         errors++;
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule
